//--- armCore.f
src/armPkg.sv
src/armAlu.sv
src/armRegFile.sv
src/armHazard.sv
src/armController.sv
src/armDatapath.sv
src/armCore.sv
test/armCore_sva.sv
test/armCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module armCoreTb \
   -Mdir obj_dir \
   -f armCore.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed"
   exit $status
fi

./obj_dir/VarmCoreTb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit $status
fi

exit 0

//--- test/armCoreTb.sv
// Testbench for the pipelined ARMv4 subset core
// Runs a hand-assembled program against instruction and data memory models
// and checks every store against an architectural model of the same program
`timescale 1ns/1ps

module armCoreTb
   import armPkg::*;
;

   logic clk, reset, memWriteM;
   wordT pcF, instrF, aluOutM, writeDataM, readDataM;

   wordT prog [0:127];
   wordT dmem [0:63];
   wordT modelMem [0:63];
   wordT modelRegs [0:15];
   wordT expAddrQ [$];
   wordT expDataQ [$];
   int   progLen, storeOff, cycles, cycleLimit;
   integer seed;

   localparam wordT haltInstr = 32'heaff_fffe;   // B to itself

   armCore armCore_i (
      .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF),
      .memWriteM(memWriteM), .aluOutM(aluOutM), .writeDataM(writeDataM),
      .readDataM(readDataM)
   );

   assign instrF    = prog[pcF[8:2]];      // Combinational ROM
   assign readDataM = dmem[aluOutM[7:2]];

   always @(posedge clk)
      if (memWriteM)
         dmem[aluOutM[7:2]] <= writeDataM;

   function automatic wordT dpInstr(input condT c, input logic [3:0] cmd, input logic s,
                                    input logic imm, input regAddrT rn, input regAddrT rd,
                                    input logic [11:0] op2);
      return {c, 2'b00, imm, cmd, s, rn, rd, op2};
   endfunction

   // Pre-indexed, offset added, word access
   function automatic wordT memInstr(input condT c, input logic load, input regAddrT rn,
                                     input regAddrT rd, input logic [11:0] off);
      return {c, 2'b01, 1'b0, 4'b1100, load, rn, rd, off};
   endfunction

   function automatic wordT brInstr(input condT c, input logic [23:0] off);
      return {c, 4'b1010, off};
   endfunction

   task automatic emit(input wordT w);
      prog[progLen] = w;
      progLen++;
   endtask

   task automatic storeReg(input condT c, input regAddrT rd);
      emit(memInstr(c, 1'b0, 4'd10, rd, storeOff[11:0]));
      storeOff += 4;
   endtask

   task automatic buildProgram();
      progLen  = 0;
      storeOff = 0;
      emit(dpInstr(4'he, 4'b0000, 1'b0, 1'b1, 4'd0, 4'd0, 12'h000));   // r0 = 0
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b1, 4'd0, 4'd1, 12'h015));
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b1, 4'd1, 4'd2, 12'h023));
      emit(dpInstr(4'he, 4'b0010, 1'b0, 1'b0, 4'd2, 4'd3, 12'h001));   // r3 = r2 - r1
      emit(dpInstr(4'he, 4'b0000, 1'b0, 1'b0, 4'd3, 4'd4, 12'h002));
      emit(dpInstr(4'he, 4'b1100, 1'b0, 1'b0, 4'd4, 4'd5, 12'h001));
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b0, 4'd5, 4'd6, 12'h003));
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b1, 4'd0, 4'd10, 12'h040)); // Store base
      for (int r = 3; r <= 6; r++)
         storeReg(condAlways, regAddrT'(r));
      emit(memInstr(4'he, 1'b1, 4'd0, 4'd7, 12'h008));
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b0, 4'd7, 4'd8, 12'h001));   // Load-use
      storeReg(condAlways, 4'd8);
      emit(memInstr(4'he, 1'b1, 4'd0, 4'd9, 12'h00c));
      storeReg(condAlways, 4'd9);                                      // Load then store it
      emit(dpInstr(4'he, 4'b0010, 1'b1, 1'b0, 4'd1, 4'd11, 12'h002));  // SUBS
      for (int k = 0; k < 14; k++)
         storeReg(condT'(k), 4'd11);
      emit(dpInstr(4'he, 4'b0100, 1'b1, 1'b0, 4'd7, 4'd12, 12'h009));  // ADDS, random data
      for (int k = 0; k < 14; k++)
         storeReg(condT'(k), 4'd12);
      emit(brInstr(4'he, 24'd1));        // Taken, skips two stores
      storeReg(condAlways, 4'd1);
      storeReg(condAlways, 4'd2);
      emit(dpInstr(4'he, 4'b0010, 1'b1, 1'b0, 4'd0, 4'd13, 12'h000));  // Z set
      emit(brInstr(4'h1, 24'd1));        // BNE not taken
      storeReg(condAlways, 4'd13);
      storeReg(condAlways, 4'd3);
      emit(dpInstr(4'he, 4'b0100, 1'b0, 1'b1, 4'd15, 4'd14, 12'h000)); // r14 = PC+8
      storeReg(condAlways, 4'd14);
      emit(haltInstr);
   endtask

   function automatic logic condHolds(input condT c, input logic n, input logic z,
                                      input logic cf, input logic v);
      case (c)
         4'h0: return z;
         4'h1: return !z;
         4'h2: return cf;
         4'h3: return !cf;
         4'h4: return n;
         4'h5: return !n;
         4'h6: return v;
         4'h7: return !v;
         4'h8: return cf && !z;
         4'h9: return !cf || z;
         4'ha: return n == v;
         4'hb: return n != v;
         4'hc: return !z && (n == v);
         4'hd: return z || (n != v);
         4'he: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic wordT regValue(input logic [3:0] r, input wordT pc);
      return (r == 4'd15) ? pc + 32'd8 : modelRegs[r];
   endfunction

   // Architectural model, fills the expected store queues
   task automatic runModel();
      wordT pc, instr, rnVal, op2, res;
      logic [32:0] sum;
      logic n, z, cf, v;
      pc = '0;
      {n, z, cf, v} = 4'b0000;
      for (int r = 0; r < 16; r++)
         modelRegs[r] = '0;
      for (int step = 0; step < 1000; step++)
      begin
         instr = prog[pc[8:2]];
         if (instr == haltInstr)
            break;
         rnVal = regValue(instr[19:16], pc);
         if (condHolds(instr[31:28], n, z, cf, v))
            case (instr[27:26])
               2'b00:
               begin
                  op2 = instr[25] ? {24'b0, instr[7:0]} : regValue(instr[3:0], pc);
                  sum = '0;
                  case (instr[24:21])
                     4'b0100: sum = {1'b0, rnVal} + {1'b0, op2};
                     4'b0010: sum = {1'b0, rnVal} + {1'b0, ~op2} + 33'd1;
                     4'b0000: sum = {1'b0, rnVal & op2};
                     default: sum = {1'b0, rnVal | op2};
                  endcase
                  res = sum[31:0];
                  modelRegs[instr[15:12]] = res;
                  if (instr[20])
                  begin
                     n = res[31];
                     z = (res == 0);
                     if (instr[24:21] == 4'b0100)
                     begin
                        cf = sum[32];
                        v  = (rnVal[31] == op2[31]) && (res[31] != rnVal[31]);
                     end
                     else if (instr[24:21] == 4'b0010)
                     begin
                        cf = sum[32];   // Set when no borrow
                        v  = (rnVal[31] != op2[31]) && (res[31] != rnVal[31]);
                     end
                  end
               end
               2'b01:
               begin
                  res = rnVal + {20'b0, instr[11:0]};
                  if (instr[20])
                     modelRegs[instr[15:12]] = modelMem[res[7:2]];
                  else
                  begin
                     expAddrQ.push_back(res);
                     expDataQ.push_back(regValue(instr[15:12], pc));
                     modelMem[res[7:2]] = regValue(instr[15:12], pc);
                  end
               end
               default:
                  pc = pc + 32'd4 + {{6{instr[23]}}, instr[23:0], 2'b00};   // +8 less the +4 below
            endcase
         pc = pc + 32'd4;
      end
   endtask

   initial
   begin
      seed = 95;
      clk   = 1'b0;
      reset = 1'b1;
      for (int i = 0; i < 128; i++)
         prog[i] = haltInstr;
      for (int i = 0; i < 64; i++)
      begin
         dmem[i]     = $random(seed);
         modelMem[i] = dmem[i];
      end
      buildProgram();
      runModel();
      cycleLimit = 4 * progLen + 50;
      repeat (10) @(negedge clk);
      reset = 1'b0;
   end

   initial
   begin
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
      if (!reset && memWriteM)
      begin
         assert (aluOutM == expAddrQ[0])
         else
         begin
            $display("mismatch at %0t: aluOutM got %h expected %h", $time, aluOutM, expAddrQ[0]);
            $display("test failed");
            $fatal(1, "store address check");
         end
         assert (writeDataM == expDataQ[0])
         else
         begin
            $display("mismatch at %0t: writeDataM got %h expected %h",
                     $time, writeDataM, expDataQ[0]);
            $display("test failed");
            $fatal(1, "store data check");
         end
         void'(expAddrQ.pop_front());
         void'(expDataQ.pop_front());
         if (expAddrQ.size() == 0)
         begin
            $display("test passed");
            $finish;
         end
      end

   always @(posedge clk)
      if (!reset)
      begin
         cycles++;
         if (cycles > cycleLimit)
         begin
            $display("timeout after %0d cycles with %0d stores still expected",
                     cycles, expAddrQ.size());
            $display("test failed");
            $fatal(1, "cycle limit reached");
         end
      end

endmodule

//--- test/armCore_sva.sv
// Bound checks on the core's memory-side outputs
// Reset state, PC alignment and a known store enable
`timescale 1ns/1ps

module armCoreSva
   import armPkg::*;
(
   input logic clk,
   input logic reset,
   input wordT pcF,
   input logic memWriteM
);

   // Held in reset state
   resetState: assert property (@(posedge clk) reset |-> (pcF == '0) && !memWriteM)
      else $error("pcF or memWriteM not cleared during reset");

   // First edge after reset fetches word zero, then the PC moves on by one word
   firstFetch: assert property (@(posedge clk) $fell(reset) |=> (pcF == 32'd4) && !memWriteM)
      else $error("fetch did not start at address zero");

   pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
      else $error("pcF not word aligned");

   memWriteKnown: assert property (@(posedge clk) !$isunknown(memWriteM))
      else $error("memWriteM is unknown");

endmodule

bind armCore armCoreSva sva_i (
   .clk(clk),
   .reset(reset),
   .pcF(pcF),
   .memWriteM(memWriteM)
);

//--- src/armCore.sv
// Five-stage pipelined core for an ARMv4 subset
// Ties together controller, datapath and hazard unit, exposes the memory ports
`timescale 1ns/1ps

module armCore
   import armPkg::*;
(
   input  logic clk,
   input  logic reset,
   output wordT pcF,
   input  wordT instrF,
   output logic memWriteM,
   output wordT aluOutM,
   output wordT writeDataM,
   input  wordT readDataM
);

   logic [1:0] regSrcD;
   immSrcT     immSrcD;
   logic       aluSrcE, branchTakenE, memToRegE;
   aluOpT      aluOpE;
   logic       memToRegW, regWriteM, regWriteW;
   wordT       instrD;
   flagsT      aluFlagsE;
   fwdSelT     fwdAE, fwdBE;
   logic       stallF, stallD, flushD, flushE;
   logic       match1EM, match1EW, match2EM, match2EW, match12DE;

   armController controller_i (
      .clk(clk), .reset(reset),
      .instrD(instrD), .aluFlagsE(aluFlagsE), .flushE(flushE),
      .regSrcD(regSrcD), .immSrcD(immSrcD),
      .aluSrcE(aluSrcE), .aluOpE(aluOpE), .branchTakenE(branchTakenE),
      .memWriteM(memWriteM), .memToRegE(memToRegE),
      .memToRegW(memToRegW), .regWriteM(regWriteM), .regWriteW(regWriteW)
   );

   armDatapath datapath_i (
      .clk(clk), .reset(reset),
      .instrF(instrF), .readDataM(readDataM),
      .regSrcD(regSrcD), .immSrcD(immSrcD),
      .aluSrcE(aluSrcE), .aluOpE(aluOpE), .branchTakenE(branchTakenE),
      .memToRegW(memToRegW), .regWriteW(regWriteW),
      .fwdAE(fwdAE), .fwdBE(fwdBE),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
      .pcF(pcF), .instrD(instrD),
      .aluOutM(aluOutM), .writeDataM(writeDataM), .aluFlagsE(aluFlagsE),
      .match1EM(match1EM), .match1EW(match1EW),
      .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE)
   );

   armHazard hazard_i (
      .match1EM(match1EM), .match1EW(match1EW),
      .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE),
      .regWriteM(regWriteM), .regWriteW(regWriteW),
      .memToRegE(memToRegE), .branchTakenE(branchTakenE),
      .fwdAE(fwdAE), .fwdBE(fwdBE),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
   );

endmodule

//--- src/armDatapath.sv
// Datapath of the pipelined core
// PC, stage registers, immediate extension, operand forwarding
// and the register-number comparators used by the hazard unit
`timescale 1ns/1ps

module armDatapath
   import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  wordT       instrF,
   input  wordT       readDataM,
   input  logic [1:0] regSrcD,
   input  immSrcT     immSrcD,
   input  logic       aluSrcE,
   input  aluOpT      aluOpE,
   input  logic       branchTakenE,
   input  logic       memToRegW,
   input  logic       regWriteW,
   input  fwdSelT     fwdAE,
   input  fwdSelT     fwdBE,
   input  logic       stallF,
   input  logic       stallD,
   input  logic       flushD,
   input  logic       flushE,
   output wordT       pcF,
   output wordT       instrD,
   output wordT       aluOutM,
   output wordT       writeDataM,
   output flagsT      aluFlagsE,
   output logic       match1EM,
   output logic       match1EW,
   output logic       match2EM,
   output logic       match2EW,
   output logic       match12DE
);

   wordT    pcPlus4F, pcNextF;
   wordT    extImmD, rd1D, rd2D;
   regAddrT ra1D, ra2D;
   wordT    rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE, aluResultE;
   regAddrT ra1E, ra2E, wa3E, wa3M, wa3W;
   wordT    aluOutW, readDataW, resultW;

   function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal,
                                   input wordT wbVal, input wordT memVal);
      case (sel)
         fwdMem:  return memVal;
         fwdWb:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;   // Target from the ALU

   always_ff @(posedge clk or posedge reset)
      if (reset)
         pcF <= '0;
      else if (!stallF)
         pcF <= pcNextF;

   always_ff @(posedge clk or posedge reset)
      if (reset)
         instrD <= bubbleInstr;
      else if (flushD)
         instrD <= bubbleInstr;
      else if (!stallD)
         instrD <= instrF;

   assign ra1D = regSrcD[0] ? pcReg : instrD[rnMsb:rnLsb];
   assign ra2D = regSrcD[1] ? instrD[rdMsb:rdLsb] : instrD[rmMsb:rmLsb];

   // pcPlus4F is already two words past the decode instruction
   armRegFile regFile_i (
      .clk(clk), .writeEn(regWriteW),
      .readAddr1(ra1D), .readAddr2(ra2D), .writeAddr(wa3W),
      .writeData(resultW), .pcPlus8(pcPlus4F),
      .readData1(rd1D), .readData2(rd2D)
   );

   always_comb
      case (immSrcD)
         immDp8:      extImmD = {24'b0, instrD[7:0]};
         immMem12:    extImmD = {20'b0, instrD[11:0]};
         immBranch24: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
         default:     extImmD = '0;
      endcase

   // Execute registers, a flushed slot carries zeros
   always_ff @(posedge clk)
   begin
      if (flushE)
      begin
         rd1E    <= '0;
         rd2E    <= '0;
         extImmE <= '0;
         ra1E    <= '0;
         ra2E    <= '0;
         wa3E    <= '0;
      end
      else
      begin
         rd1E    <= rd1D;
         rd2E    <= rd2D;
         extImmE <= extImmD;
         ra1E    <= ra1D;
         ra2E    <= ra2D;
         wa3E    <= instrD[rdMsb:rdLsb];
      end
   end

   assign srcAE      = fwdMux(fwdAE, rd1E, resultW, aluOutM);
   assign writeDataE = fwdMux(fwdBE, rd2E, resultW, aluOutM);
   assign srcBE      = aluSrcE ? extImmE : writeDataE;

   armAlu alu_i (
      .a(srcAE), .b(srcBE), .op(aluOpE),
      .result(aluResultE), .flags(aluFlagsE)
   );

   always_ff @(posedge clk)
   begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      wa3M       <= wa3E;
      aluOutW    <= aluOutM;
      readDataW  <= readDataM;
      wa3W       <= wa3M;
   end

   assign resultW = memToRegW ? readDataW : aluOutW;

   assign match1EM  = (wa3M == ra1E);
   assign match1EW  = (wa3W == ra1E);
   assign match2EM  = (wa3M == ra2E);
   assign match2EW  = (wa3W == ra2E);
   assign match12DE = (wa3E == ra1D) || (wa3E == ra2D);   // Load-use check

endmodule

//--- src/armController.sv
// Control unit of the pipelined core
// Decodes instructions, checks conditions against NZCV and carries
// the control bits down to writeback
`timescale 1ns/1ps

module armController
   import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  wordT       instrD,
   input  flagsT      aluFlagsE,
   input  logic       flushE,
   output logic [1:0] regSrcD,
   output immSrcT     immSrcD,
   output logic       aluSrcE,
   output aluOpT      aluOpE,
   output logic       branchTakenE,
   output logic       memWriteM,
   output logic       memToRegE,
   output logic       memToRegW,
   output logic       regWriteM,
   output logic       regWriteW
);

   logic [1:0] opD, flagWriteD, flagWriteE;
   logic [3:0] cmdD;
   logic       immBitD, sBitD, isDataD;
   logic       aluSrcD, memToRegD, regWriteD, memWriteD, branchD;
   aluOpT      aluOpD;
   logic       branchE, memWriteE, regWriteE, memToRegM;
   condT       condE;
   flagsT      flagsE, flagsNextE;
   logic       flagN, flagZ, flagC, flagV, signedGe, condExE;

   assign opD     = instrD[opMsb:opLsb];
   assign cmdD    = instrD[functMsb-1:functLsb+1];
   assign immBitD = instrD[functMsb];
   assign sBitD   = instrD[functLsb];   // L bit for memory ops

   always_comb
   begin
      regSrcD   = 2'b00;
      immSrcD   = immDp8;
      aluSrcD   = 1'b0;
      memToRegD = 1'b0;
      regWriteD = 1'b0;
      memWriteD = 1'b0;
      branchD   = 1'b0;
      isDataD   = 1'b0;
      case (opD)
         opData:
         begin
            aluSrcD   = immBitD;
            regWriteD = 1'b1;
            isDataD   = 1'b1;
         end
         opMem:
         begin
            immSrcD = immMem12;
            aluSrcD = 1'b1;   // Base plus offset
            if (sBitD)
            begin
               memToRegD = 1'b1;
               regWriteD = 1'b1;
            end
            else
            begin
               regSrcD[1] = 1'b1;   // Store data comes from Rd
               memWriteD  = 1'b1;
            end
         end
         opBranch:
         begin
            regSrcD[0] = 1'b1;   // Rn replaced by R15
            immSrcD    = immBranch24;
            aluSrcD    = 1'b1;
            branchD    = 1'b1;
         end
         default: ;
      endcase
   end

   always_comb
   begin
      aluOpD     = aluAdd;   // Address and target adds
      flagWriteD = 2'b00;
      if (isDataD)
      begin
         case (cmdD)
            functSub: aluOpD = aluSub;
            functAnd: aluOpD = aluAnd;
            functOrr: aluOpD = aluOrr;
            default:  aluOpD = aluAdd;
         endcase
         flagWriteD[1] = sBitD;
         flagWriteD[0] = sBitD && (cmdD == functAdd || cmdD == functSub);
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         aluSrcE    <= 1'b0;
         aluOpE     <= aluAdd;
         condE      <= '0;
         flagWriteE <= 2'b00;
         branchE    <= 1'b0;
         memWriteE  <= 1'b0;
         regWriteE  <= 1'b0;
         memToRegE  <= 1'b0;
      end
      else
      begin
         aluSrcE <= aluSrcD;
         aluOpE  <= aluOpD;
         condE   <= instrD[condMsb:condLsb];
         if (flushE)
         begin
            flagWriteE <= 2'b00;
            branchE    <= 1'b0;
            memWriteE  <= 1'b0;
            regWriteE  <= 1'b0;
            memToRegE  <= 1'b0;
         end
         else
         begin
            flagWriteE <= flagWriteD;
            branchE    <= branchD;
            memWriteE  <= memWriteD;
            regWriteE  <= regWriteD;
            memToRegE  <= memToRegD;
         end
      end
   end

   assign {flagN, flagZ, flagC, flagV} = flagsE;
   assign signedGe = (flagN == flagV);

   always_comb
      case (condE)
         4'b0000:    condExE = flagZ;                // EQ
         4'b0001:    condExE = !flagZ;               // NE
         4'b0010:    condExE = flagC;                // CS
         4'b0011:    condExE = !flagC;               // CC
         4'b0100:    condExE = flagN;                // MI
         4'b0101:    condExE = !flagN;               // PL
         4'b0110:    condExE = flagV;                // VS
         4'b0111:    condExE = !flagV;               // VC
         4'b1000:    condExE = flagC && !flagZ;      // HI
         4'b1001:    condExE = !flagC || flagZ;      // LS
         4'b1010:    condExE = signedGe;             // GE
         4'b1011:    condExE = !signedGe;            // LT
         4'b1100:    condExE = !flagZ && signedGe;   // GT
         4'b1101:    condExE = flagZ || !signedGe;   // LE
         condAlways: condExE = 1'b1;
         default:    condExE = 1'b0;   // NV, also the bubble
      endcase

   // Flags only commit when the instruction actually executes
   assign flagsNextE[3:2] = (flagWriteE[1] && condExE) ? aluFlagsE[3:2] : flagsE[3:2];
   assign flagsNextE[1:0] = (flagWriteE[0] && condExE) ? aluFlagsE[1:0] : flagsE[1:0];
   assign branchTakenE    = branchE && condExE;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flagsE    <= '0;
         memWriteM <= 1'b0;
         memToRegM <= 1'b0;
         regWriteM <= 1'b0;
         memToRegW <= 1'b0;
         regWriteW <= 1'b0;
      end
      else
      begin
         flagsE    <= flagsNextE;
         memWriteM <= memWriteE && condExE;
         memToRegM <= memToRegE;
         regWriteM <= regWriteE && condExE;
         memToRegW <= memToRegM;
         regWriteW <= regWriteM;
      end
   end

endmodule

//--- src/armHazard.sv
// Hazard unit of the pipelined core
// Forwarding selects, load-use stall and taken-branch flush
`timescale 1ns/1ps

module armHazard
   import armPkg::*;
(
   input  logic   match1EM,
   input  logic   match1EW,
   input  logic   match2EM,
   input  logic   match2EW,
   input  logic   match12DE,
   input  logic   regWriteM,
   input  logic   regWriteW,
   input  logic   memToRegE,
   input  logic   branchTakenE,
   output fwdSelT fwdAE,
   output fwdSelT fwdBE,
   output logic   stallF,
   output logic   stallD,
   output logic   flushD,
   output logic   flushE
);

   logic loadUseStall;

   // Memory stage holds the newer value, so it wins
   always_comb
   begin
      if (match1EM && regWriteM)
         fwdAE = fwdMem;
      else if (match1EW && regWriteW)
         fwdAE = fwdWb;
      else
         fwdAE = fwdNone;
      if (match2EM && regWriteM)
         fwdBE = fwdMem;
      else if (match2EW && regWriteW)
         fwdBE = fwdWb;
      else
         fwdBE = fwdNone;
   end

   assign loadUseStall = match12DE && memToRegE;   // Loaded data not ready until writeback

   assign stallF = loadUseStall;
   assign stallD = loadUseStall;
   assign flushD = branchTakenE;
   assign flushE = loadUseStall || branchTakenE;

endmodule

//--- src/armRegFile.sv
// Register file with fifteen general registers
// Written on the falling edge so decode sees the value in the same cycle
`timescale 1ns/1ps

module armRegFile
   import armPkg::*;
(
   input  logic    clk,
   input  logic    writeEn,
   input  regAddrT readAddr1,
   input  regAddrT readAddr2,
   input  regAddrT writeAddr,
   input  wordT    writeData,
   input  wordT    pcPlus8,
   output wordT    readData1,
   output wordT    readData2
);

   wordT regs [0:regCount-2];   // R0 to R14

   always_ff @(negedge clk)
      if (writeEn && writeAddr != pcReg)
         regs[writeAddr] <= writeData;

   // R15 is not stored
   assign readData1 = (readAddr1 == pcReg) ? pcPlus8 : regs[readAddr1];
   assign readData2 = (readAddr2 == pcReg) ? pcPlus8 : regs[readAddr2];

endmodule

//--- src/armAlu.sv
// ALU with add, subtract, AND and OR
// Produces NZCV, with C and V cleared for logic operations
`timescale 1ns/1ps

module armAlu
   import armPkg::*;
(
   input  wordT  a,
   input  wordT  b,
   input  aluOpT op,
   output wordT  result,
   output flagsT flags
);

   logic              isSub, isArith;
   wordT              bMaybeInv;
   logic [dataWidth:0] sum;

   assign isSub     = (op == aluSub);
   assign isArith   = (op == aluAdd) || (op == aluSub);
   assign bMaybeInv = isSub ? ~b : b;
   assign sum       = {1'b0, a} + {1'b0, bMaybeInv} + {{dataWidth{1'b0}}, isSub};

   always_comb
      case (op)
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         default: result = sum[dataWidth-1:0];
      endcase

   // Overflow when both operands agree in sign and the sum does not
   assign flags[3] = result[dataWidth-1];
   assign flags[2] = (result == '0);
   assign flags[1] = isArith && sum[dataWidth];
   assign flags[0] = isArith && (a[dataWidth-1] == bMaybeInv[dataWidth-1])
                     && (a[dataWidth-1] != sum[dataWidth-1]);

endmodule

//--- src/armPkg.sv
// Shared definitions for the pipelined ARMv4 subset core
// Instruction field positions, opcode and condition encodings, datapath types
package armPkg;

   localparam int dataWidth = 32;
   localparam int regCount  = 16;

   typedef logic [dataWidth-1:0]        wordT;
   typedef logic [$clog2(regCount)-1:0] regAddrT;
   typedef logic [3:0]                  flagsT;   // N Z C V
   typedef logic [3:0]                  condT;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOrr} aluOpT;
   typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwdSelT;
   typedef enum logic [1:0] {immDp8, immMem12, immBranch24} immSrcT;

   localparam regAddrT pcReg = 4'd15;

   // Instruction field positions
   localparam int condMsb  = 31;
   localparam int condLsb  = 28;
   localparam int opMsb    = 27;
   localparam int opLsb    = 26;
   localparam int functMsb = 25;   // I bit for data processing
   localparam int functLsb = 20;   // S bit, or L bit for memory
   localparam int rnMsb    = 19;
   localparam int rnLsb    = 16;
   localparam int rdMsb    = 15;
   localparam int rdLsb    = 12;
   localparam int rmMsb    = 3;
   localparam int rmLsb    = 0;

   localparam logic [1:0] opData   = 2'b00;
   localparam logic [1:0] opMem    = 2'b01;
   localparam logic [1:0] opBranch = 2'b10;

   // Data processing cmd, funct bits 4..1
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functOrr = 4'b1100;

   localparam condT condAlways  = 4'b1110;
   localparam wordT bubbleInstr = 32'hf000_0000;   // Cond NV, never executes

endpackage
